//--- vlog.f
hw/mips_pkg.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_memory.sv
hw/mips_hazard.sv
hw/mips_core.sv
dv/mips_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the MIPS core testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module mips_core_tb \
	-Mdir obj_dir -o mips_core_tb > build.log 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/mips_core_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q 'All tests passed!' sim.log; then
	if [ "$sim_status" -ne 0 ]; then
		echo "Simulator exited with status $sim_status"
		exit 1
	fi
	exit 0
fi

echo "Simulation did not pass, see sim.log"
exit 1

//--- dv/mips_core_tb.sv
/*
 * Testbench for the pipelined MIPS core. Builds a program from an operation table,
 * models instruction and data memory, and checks every store and the sys pulse.
 */
`timescale 1ns/1ps

module mips_core_tb;

	// --------------------
	// Encodings and layout
	// --------------------
	localparam logic [31:0] reset_vector = 32'h0000_0000;
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_andi = 6'h0c;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;
	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_syscall = 6'h0c;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	// Register roles in the program
	localparam logic [4:0] r_zero = 5'd0;
	localparam logic [4:0] r_a = 5'd1;
	localparam logic [4:0] r_b = 5'd2;
	localparam logic [4:0] r_res = 5'd3;
	localparam logic [4:0] r_x = 5'd4;
	localparam logic [4:0] r_y = 5'd5;
	localparam logic [4:0] r_ld = 5'd6;
	localparam logic [4:0] r_sum = 5'd7;

	// Store addresses past the table results
	localparam logic [15:0] addr_x = 16'h0100;
	localparam logic [15:0] addr_sum = 16'h0104;
	localparam logic [15:0] addr_mark0 = 16'h0200;
	localparam logic [15:0] addr_mark1 = 16'h0204;
	localparam logic [15:0] addr_mark2 = 16'h0208;

	localparam int k_addu = 0;
	localparam int k_subu = 1;
	localparam int k_and = 2;
	localparam int k_or = 3;
	localparam int k_slt = 4;
	localparam int k_sll = 5;
	localparam int k_addiu = 6;
	localparam int k_andi = 7;
	localparam int k_ori = 8;
	localparam int k_lui = 9;

	logic clock = 1'b0;
	logic rst_n = 1'b0;
	logic [31:0] instruction_in;
	logic [31:0] data_in;
	logic [31:0] instruction_address;
	logic [31:0] data_address;
	logic [31:0] data_out;
	logic mem_read;
	logic mem_write;
	logic sys;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [7:0] emit_ptr;
	logic [31:0] rng_state = 32'd8645;

	// Operation table
	int kinds[$];
	logic [31:0] operand_a[$];
	logic [31:0] operand_b[$];
	logic [31:0] expected[$];

	logic [31:0] exp_store [logic [31:0]];
	bit seen [logic [31:0]];
	int seen_count = 0;
	int load_count = 0;
	int sys_pulses = 0;
	logic sys_prev = 1'b0;
	int cycles = 0;
	int program_length = 0;
	int timeout_limit = 0;

	always #10 clock = ~clock;

	mips_core #(
		.reset_vector(reset_vector)
	) DUT (
		.clock(clock),
		.rst_n(rst_n),
		.instruction_in(instruction_in),
		.data_in(data_in),
		.instruction_address(instruction_address),
		.data_address(data_address),
		.data_out(data_out),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.sys(sys)
	);

	// --------------------
	// Memory models
	// --------------------
	assign instruction_in = imem[instruction_address[9:2]];
	assign data_in = dmem[data_address[9:2]];

	// Fill tracks the address so stale reads show up
	always @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i[7:0]] <= 32'hA5A5_0000 ^ {22'h0, i[7:0], 2'b00};
			end
		end else if (mem_write) begin
			dmem[data_address[9:2]] <= data_out;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		return {op_special, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// MIPS I semantics of each table kind
	function automatic logic [31:0] reference_result(input int kind, input logic [31:0] a,
		input logic [31:0] b);
		case (kind)
			k_addu: return a + b;
			k_subu: return a - b;
			k_and: return a & b;
			k_or: return a | b;
			k_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			// rt shifted by the low bits of a
			k_sll: return b << a[4:0];
			k_addiu: return a + {{16{b[15]}}, b[15:0]};
			k_andi: return a & {16'h0000, b[15:0]};
			k_ori: return a | {16'h0000, b[15:0]};
			k_lui: return {b[15:0], 16'h0000};
			default: return 32'h0;
		endcase
	endfunction

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input logic [31:0] actual,
		input logic [31:0] want);
		if (actual !== want) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, want);
			abort_run();
		end
	endtask

	task automatic emit(input logic [31:0] word);
		imem[emit_ptr] = word;
		emit_ptr = emit_ptr + 8'd1;
		program_length = program_length + 1;
	endtask

	// Upper half by lui and lower half by ori right before the use
	task automatic load_word(input logic [4:0] rd, input logic [31:0] value);
		emit(encode_i(op_lui, r_zero, rd, value[31:16]));
		emit(encode_i(op_ori, rd, rd, value[15:0]));
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] op_word;
		logic [15:0] addr;
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = 32'h0000_0000;
		end
		emit_ptr = reset_vector[9:2];
		kinds = '{k_addu, k_subu, k_and, k_or, k_slt, k_sll, k_addiu, k_andi, k_ori, k_lui,
			k_slt, k_addu};
		foreach (kinds[i]) begin
			rng_state = xorshift(rng_state);
			a = rng_state;
			rng_state = xorshift(rng_state);
			b = rng_state;
			// Negative immediate for addiu
			if (kinds[i] == k_addiu) begin
				b[15] = 1'b1;
			end
			operand_a.push_back(a);
			operand_b.push_back(b);
			expected.push_back(reference_result(kinds[i], a, b));
		end

		// --------------------
		// One result store per table entry
		// --------------------
		addr = 16'h0000;
		foreach (kinds[i]) begin
			load_word(r_a, operand_a[i]);
			load_word(r_b, operand_b[i]);
			case (kinds[i])
				k_addu: op_word = encode_r(r_a, r_b, r_res, 5'd0, fn_addu);
				k_subu: op_word = encode_r(r_a, r_b, r_res, 5'd0, fn_subu);
				k_and: op_word = encode_r(r_a, r_b, r_res, 5'd0, fn_and);
				k_or: op_word = encode_r(r_a, r_b, r_res, 5'd0, fn_or);
				k_slt: op_word = encode_r(r_a, r_b, r_res, 5'd0, fn_slt);
				k_sll: op_word = encode_r(r_zero, r_b, r_res, operand_a[i][4:0], fn_sll);
				k_addiu: op_word = encode_i(op_addiu, r_a, r_res, operand_b[i][15:0]);
				k_andi: op_word = encode_i(op_andi, r_a, r_res, operand_b[i][15:0]);
				k_ori: op_word = encode_i(op_ori, r_a, r_res, operand_b[i][15:0]);
				default: op_word = encode_i(op_lui, r_zero, r_res, operand_b[i][15:0]);
			endcase
			emit(op_word);
			emit(encode_i(op_sw, r_zero, r_res, addr));
			exp_store[{16'h0000, addr}] = expected[i];
			addr = addr + 16'd4;
		end

		// The addu right after the lw needs one bubble
		rng_state = xorshift(rng_state);
		x = rng_state | 32'h0000_0001;
		rng_state = xorshift(rng_state);
		y = rng_state;
		load_word(r_x, x);
		emit(encode_i(op_sw, r_zero, r_x, addr_x));
		load_word(r_y, y);
		emit(encode_i(op_lw, r_zero, r_ld, addr_x));
		emit(encode_r(r_ld, r_y, r_sum, 5'd0, fn_addu));
		emit(encode_i(op_sw, r_zero, r_sum, addr_sum));
		exp_store[{16'h0000, addr_x}] = x;
		exp_store[{16'h0000, addr_sum}] = x + y;

		// A taken beq skips two markers and a not-taken beq lets the third through
		emit(encode_i(op_beq, r_zero, r_zero, 16'd2));
		emit(encode_i(op_sw, r_zero, r_x, addr_mark0));
		emit(encode_i(op_sw, r_zero, r_x, addr_mark1));
		emit(encode_i(op_beq, r_x, r_zero, 16'd1));
		emit(encode_i(op_sw, r_zero, r_x, addr_mark2));
		exp_store[{16'h0000, addr_mark2}] = x;
		emit(encode_r(r_zero, r_zero, r_zero, 5'd0, fn_syscall));
		timeout_limit = 4 * program_length + 100;
	endtask

	task automatic record_store();
		logic [31:0] addr;
		addr = data_address;
		if (!exp_store.exists(addr)) begin
			$display("Store to unexpected address 0x%h", addr);
			abort_run();
		end else if (seen.exists(addr)) begin
			$display("Second store to address 0x%h", addr);
			abort_run();
		end else begin
			compare_word($sformatf("data_out at 0x%h", addr), data_out, exp_store[addr]);
			seen[addr] = 1'b1;
			seen_count = seen_count + 1;
		end
	endtask

	// --------------------
	// Monitor sampled mid-cycle
	// --------------------
	always @(negedge clock) begin
		if (!rst_n) begin
			compare_word("mem_read", {31'h0, mem_read}, 32'h0);
			compare_word("mem_write", {31'h0, mem_write}, 32'h0);
			compare_word("sys", {31'h0, sys}, 32'h0);
		end else begin
			cycles = cycles + 1;
			if (cycles > timeout_limit) begin
				$display("Timeout: no sys pulse within %0d cycles", timeout_limit);
				abort_run();
			end
			if (mem_write === 1'b1) begin
				record_store();
			end
			// The only lw in the program reads back x
			if (mem_read === 1'b1) begin
				compare_word("data_address at load", data_address, {16'h0000, addr_x});
				load_count = load_count + 1;
			end
			if (sys === 1'b1) begin
				if (sys_prev === 1'b1) begin
					$display("sys stayed high for more than one cycle");
					abort_run();
				end else if (sys_pulses != 0) begin
					$display("sys pulsed a second time");
					abort_run();
				end else if (seen_count != exp_store.size()) begin
					$display("sys pulsed before every expected store was seen");
					abort_run();
				end
				sys_pulses = sys_pulses + 1;
			end
			sys_prev = sys;
		end
	end

	initial begin
		build_program();
		repeat (10) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		compare_word("instruction_address", instruction_address, reset_vector);
		wait (sys_pulses != 0);
		// Drain so a late pulse or stray store is caught
		repeat (10) @(posedge clock);
		if (seen_count != exp_store.size()) begin
			$display("Only %0d of %0d expected stores seen", seen_count, exp_store.size());
			abort_run();
		end else if (load_count != 1) begin
			$display("Expected one load cycle but saw %0d", load_count);
			abort_run();
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

//--- hw/mips_core.sv
/*
 * Top level of the five-stage core; wires stages and hazard unit to memory ports.
 */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
	parameter word_t reset_vector = '0
) (
	input logic clock,
	input logic rst_n,
	input word_t instruction_in,
	input word_t data_in,
	output word_t instruction_address,
	output word_t data_address,
	output word_t data_out,
	output logic mem_read,
	output logic mem_write,
	output logic sys
);

	// --------------------
	// Stage wires
	// --------------------
	// IF/ID
	word_t instruction;
	word_t pc_plus4;
	// ID/EXE
	word_t ex_operand_a;
	word_t ex_operand_b;
	word_t ex_immediate;
	word_t ex_store_data;
	word_t ex_branch_target;
	reg_addr_t ex_rs;
	reg_addr_t ex_rt;
	reg_addr_t ex_destination;
	alu_op_t ex_alu_op;
	shamt_t ex_shamt;
	logic ex_use_immediate;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_write_enable;
	logic ex_branch;
	logic ex_syscall;
	// Decode to hazard
	reg_addr_t id_rs;
	reg_addr_t id_rt;
	// Execute outputs
	logic branch_taken;
	word_t branch_target;
	logic mem_write_enable;
	logic mem_syscall;
	reg_addr_t mem_destination;
	// MEM/WB
	logic wb_enable;
	reg_addr_t wb_register;
	word_t wb_data;
	// Hazard
	logic stall;
	logic flush;

	mips_fetch #(
		.reset_vector(reset_vector)
	) u_fetch (
		.clock(clock),
		.rst_n(rst_n),
		.stall(stall),
		.flush(flush),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.instruction_in(instruction_in),
		.instruction_address(instruction_address),
		.instruction(instruction),
		.pc_plus4(pc_plus4)
	);

	mips_decode u_decode (
		.clock(clock),
		.rst_n(rst_n),
		.stall(stall),
		.flush(flush),
		.instruction(instruction),
		.pc_plus4(pc_plus4),
		.wb_enable(wb_enable),
		.wb_register(wb_register),
		.wb_data(wb_data),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b),
		.ex_immediate(ex_immediate),
		.ex_store_data(ex_store_data),
		.ex_branch_target(ex_branch_target),
		.ex_rs(ex_rs),
		.ex_rt(ex_rt),
		.ex_destination(ex_destination),
		.ex_alu_op(ex_alu_op),
		.ex_shamt(ex_shamt),
		.ex_use_immediate(ex_use_immediate),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_write_enable(ex_write_enable),
		.ex_branch(ex_branch),
		.ex_syscall(ex_syscall),
		.id_rs(id_rs),
		.id_rt(id_rt)
	);

	// EXE/MEM drives the data memory ports directly
	mips_execute u_execute (
		.clock(clock),
		.rst_n(rst_n),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b),
		.ex_immediate(ex_immediate),
		.ex_store_data(ex_store_data),
		.ex_branch_target(ex_branch_target),
		.ex_rs(ex_rs),
		.ex_rt(ex_rt),
		.ex_destination(ex_destination),
		.ex_alu_op(ex_alu_op),
		.ex_shamt(ex_shamt),
		.ex_use_immediate(ex_use_immediate),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_write_enable(ex_write_enable),
		.ex_branch(ex_branch),
		.ex_syscall(ex_syscall),
		.wb_enable(wb_enable),
		.wb_register(wb_register),
		.wb_data(wb_data),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.data_address(data_address),
		.data_out(data_out),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_write_enable(mem_write_enable),
		.mem_syscall(mem_syscall),
		.mem_destination(mem_destination)
	);

	mips_memory u_memory (
		.clock(clock),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write_enable(mem_write_enable),
		.mem_syscall(mem_syscall),
		.data_address(data_address),
		.data_in(data_in),
		.mem_destination(mem_destination),
		.wb_enable(wb_enable),
		.wb_register(wb_register),
		.wb_data(wb_data),
		.sys(sys)
	);

	mips_hazard u_hazard (
		.clock(clock),
		.rst_n(rst_n),
		.id_rs(id_rs),
		.id_rt(id_rt),
		.ex_destination(ex_destination),
		.ex_mem_read(ex_mem_read),
		.branch_taken(branch_taken),
		.stall(stall),
		.flush(flush)
	);

endmodule

//--- hw/mips_hazard.sv
/*
 * Hazard unit that drives load-use stall and branch flush into fetch and decode.
 * The logic is combinational and the clock only samples the assertion.
 */
`timescale 1ns/1ps

module mips_hazard import mips_pkg::*; (
	input logic clock,
	input logic rst_n,
	input reg_addr_t id_rs,
	input reg_addr_t id_rt,
	input reg_addr_t ex_destination,
	input logic ex_mem_read,
	input logic branch_taken,
	output logic stall,
	output logic flush
);

	logic load_use;

	// Unread sources arrive as $0 and never match
	assign load_use = ex_mem_read && (ex_destination != '0) &&
		(ex_destination == id_rs || ex_destination == id_rt);

	// Flush overrides the stall
	assign flush = branch_taken;
	assign stall = load_use && !branch_taken;

	// --------------------
	// Checks
	// --------------------
	// The bubble put into ID/EXE must clear the hazard next cycle
	a_single_stall: assert property (@(posedge clock) disable iff (!rst_n)
		stall |=> !stall);

endmodule

//--- hw/mips_memory.sv
/*
 * Memory stage: picks loaded data or the ALU result and loads MEM/WB.
 * The registered syscall bit is the one-cycle sys pulse.
 */
`timescale 1ns/1ps

module mips_memory import mips_pkg::*; (
	input logic clock,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write_enable,
	input logic mem_syscall,
	input word_t data_address,
	input word_t data_in,
	input reg_addr_t mem_destination,
	output logic wb_enable,
	output reg_addr_t wb_register,
	output word_t wb_data,
	output logic sys
);

	word_t result;

	// Data returns in the same cycle as the address
	assign result = mem_read ? data_in : data_address;

	// --------------------
	// MEM/WB register
	// --------------------
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_enable <= 1'b0;
			sys <= 1'b0;
		end else begin
			wb_enable <= mem_write_enable;
			// High while the syscall sits in MEM/WB
			sys <= mem_syscall;
		end
	end

	always_ff @(posedge clock) begin
		wb_register <= mem_destination;
		wb_data <= result;
	end

endmodule

//--- hw/mips_execute.sv
/*
 * Execute stage: operand forwarding, ALU, beq compare and the EXE/MEM register.
 * A taken branch is reported combinationally to fetch and the hazard unit.
 */
`timescale 1ns/1ps

module mips_execute import mips_pkg::*; (
	input logic clock,
	input logic rst_n,
	input word_t ex_operand_a,
	input word_t ex_operand_b,
	input word_t ex_immediate,
	input word_t ex_store_data,
	input word_t ex_branch_target,
	input reg_addr_t ex_rs,
	input reg_addr_t ex_rt,
	input reg_addr_t ex_destination,
	input alu_op_t ex_alu_op,
	input shamt_t ex_shamt,
	input logic ex_use_immediate,
	input logic ex_mem_read,
	input logic ex_mem_write,
	input logic ex_write_enable,
	input logic ex_branch,
	input logic ex_syscall,
	input logic wb_enable,
	input reg_addr_t wb_register,
	input word_t wb_data,
	output logic branch_taken,
	output word_t branch_target,
	output word_t data_address,
	output word_t data_out,
	output logic mem_read,
	output logic mem_write,
	output logic mem_write_enable,
	output logic mem_syscall,
	output reg_addr_t mem_destination
);

	word_t fwd_a;
	word_t fwd_b;
	word_t fwd_store;
	word_t alu_b;
	word_t alu_result;

	// Youngest producer first, $0 never forwarded
	function automatic word_t forward(input word_t base, input reg_addr_t src);
		if (src == '0) begin
			return base;
		end else if (mem_write_enable && mem_destination == src) begin
			return data_address;
		end else if (wb_enable && wb_register == src) begin
			return wb_data;
		end
		return base;
	endfunction

	// --------------------
	// Forwarding
	// --------------------
	always_comb begin
		fwd_a = forward(ex_operand_a, ex_rs);
		fwd_b = forward(ex_operand_b, ex_rt);
		// Store data sees the same bypass as rt
		fwd_store = forward(ex_store_data, ex_rt);
	end

	assign alu_b = ex_use_immediate ? ex_immediate : fwd_b;

	// --------------------
	// ALU
	// --------------------
	always_comb begin
		case (ex_alu_op)
			alu_add: alu_result = fwd_a + alu_b;
			alu_sub: alu_result = fwd_a - alu_b;
			alu_and: alu_result = fwd_a & alu_b;
			alu_or: alu_result = fwd_a | alu_b;
			alu_slt: alu_result = ($signed(fwd_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
			// Shift of rt by shamt
			alu_sll: alu_result = alu_b << ex_shamt;
			alu_lui: alu_result = {alu_b[15:0], 16'h0000};
			default: alu_result = '0;
		endcase
	end

	// beq resolved here, no delay slot
	assign branch_taken = ex_branch && (fwd_a == fwd_b);
	assign branch_target = ex_branch_target;

	// --------------------
	// EXE/MEM register
	// --------------------
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			mem_write_enable <= 1'b0;
			mem_syscall <= 1'b0;
		end else begin
			mem_read <= ex_mem_read;
			mem_write <= ex_mem_write;
			mem_write_enable <= ex_write_enable;
			mem_syscall <= ex_syscall;
		end
	end

	// Address doubles as the ALU result for writeback
	always_ff @(posedge clock) begin
		data_address <= alu_result;
		data_out <= fwd_store;
		mem_destination <= ex_destination;
	end

	// Decode never sets both, bubbles clear both
	a_rw_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
		!(mem_read && mem_write));

endmodule

//--- hw/mips_decode.sv
/*
 * Decode stage: control decode, immediate extension, register file and ID/EXE.
 * Unknown encodings become no-operations; a stall or flush enters a bubble.
 */
`timescale 1ns/1ps

module mips_decode import mips_pkg::*; (
	input logic clock,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input word_t instruction,
	input word_t pc_plus4,
	input logic wb_enable,
	input reg_addr_t wb_register,
	input word_t wb_data,
	output word_t ex_operand_a,
	output word_t ex_operand_b,
	output word_t ex_immediate,
	output word_t ex_store_data,
	output word_t ex_branch_target,
	output reg_addr_t ex_rs,
	output reg_addr_t ex_rt,
	output reg_addr_t ex_destination,
	output alu_op_t ex_alu_op,
	output shamt_t ex_shamt,
	output logic ex_use_immediate,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_write_enable,
	output logic ex_branch,
	output logic ex_syscall,
	output reg_addr_t id_rs,
	output reg_addr_t id_rt
);

	// Instruction fields
	opcode_t opcode;
	opcode_t funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic [15:0] imm16;

	// Decoded controls
	alu_op_t alu_op;
	reg_addr_t destination;
	word_t immediate;
	logic use_immediate;
	logic sign_extend;
	logic reads_rs;
	logic reads_rt;
	logic write_enable;
	logic mem_read;
	logic mem_write;
	logic branch;
	logic syscall;

	word_t regs [32];
	word_t read_a;
	word_t read_b;

	assign opcode = instruction[31:26];
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign funct = instruction[5:0];
	assign imm16 = instruction[15:0];

	// --------------------
	// Control decode
	// --------------------
	always_comb begin
		alu_op = alu_add;
		destination = rt;
		use_immediate = 1'b1;
		sign_extend = 1'b1;
		reads_rs = 1'b1;
		reads_rt = 1'b0;
		write_enable = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		syscall = 1'b0;
		case (opcode)
			op_special: begin
				destination = rd;
				use_immediate = 1'b0;
				reads_rt = 1'b1;
				write_enable = 1'b1;
				case (funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or: alu_op = alu_or;
					fn_slt: alu_op = alu_slt;
					fn_sll: begin
						alu_op = alu_sll;
						reads_rs = 1'b0;
					end
					fn_syscall: begin
						syscall = 1'b1;
						write_enable = 1'b0;
						reads_rs = 1'b0;
						reads_rt = 1'b0;
					end
					// Anything else is dropped as a nop
					default: begin
						write_enable = 1'b0;
						reads_rs = 1'b0;
						reads_rt = 1'b0;
					end
				endcase
			end
			op_addiu: write_enable = 1'b1;
			op_andi: begin
				alu_op = alu_and;
				sign_extend = 1'b0;
				write_enable = 1'b1;
			end
			op_ori: begin
				alu_op = alu_or;
				sign_extend = 1'b0;
				write_enable = 1'b1;
			end
			op_lui: begin
				alu_op = alu_lui;
				sign_extend = 1'b0;
				reads_rs = 1'b0;
				write_enable = 1'b1;
			end
			op_lw: begin
				mem_read = 1'b1;
				write_enable = 1'b1;
			end
			op_sw: begin
				mem_write = 1'b1;
				reads_rt = 1'b1;
			end
			op_beq: begin
				alu_op = alu_sub;
				use_immediate = 1'b0;
				reads_rt = 1'b1;
				branch = 1'b1;
			end
			default: reads_rs = 1'b0;
		endcase
	end

	assign immediate = sign_extend ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

	// Unused sources read as zero so the hazard unit ignores them
	assign id_rs = reads_rs ? rs : '0;
	assign id_rt = reads_rt ? rt : '0;

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge clock) begin
		if (wb_enable) begin
			regs[wb_register] <= wb_data;
		end
	end

	// Zero hardwired, writeback visible in the same cycle
	assign read_a = (rs == '0) ? '0 :
		(wb_enable && wb_register == rs) ? wb_data : regs[rs];
	assign read_b = (rt == '0) ? '0 :
		(wb_enable && wb_register == rt) ? wb_data : regs[rt];

	// --------------------
	// ID/EXE register
	// --------------------
	always_ff @(posedge clock) begin
		if (!rst_n || stall || flush) begin
			ex_write_enable <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_branch <= 1'b0;
			ex_syscall <= 1'b0;
		end else begin
			// Writes to $0 die here
			ex_write_enable <= write_enable && (destination != '0);
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
			ex_branch <= branch;
			ex_syscall <= syscall;
		end
	end

	always_ff @(posedge clock) begin
		ex_operand_a <= read_a;
		ex_operand_b <= read_b;
		ex_store_data <= read_b;
		ex_immediate <= immediate;
		ex_branch_target <= pc_plus4 + {immediate[29:0], 2'b00};
		ex_rs <= id_rs;
		ex_rt <= id_rt;
		ex_destination <= destination;
		ex_alu_op <= alu_op;
		ex_shamt <= instruction[10:6];
		ex_use_immediate <= use_immediate;
	end

	// Writes to $0 must be filtered before they reach writeback
	a_no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
		wb_enable |-> wb_register != '0);

endmodule

//--- hw/mips_fetch.sv
/*
 * Fetch stage: program counter and the IF/ID register.
 * Stall holds both, flush inserts a no-operation, a taken branch redirects.
 */
`timescale 1ns/1ps

module mips_fetch import mips_pkg::*; #(
	parameter word_t reset_vector = '0
) (
	input logic clock,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input logic branch_taken,
	input word_t branch_target,
	input word_t instruction_in,
	output word_t instruction_address,
	output word_t instruction,
	output word_t pc_plus4
);

	word_t pc;
	word_t next_sequential;

	assign next_sequential = pc + 32'd4;
	assign instruction_address = pc;

	// --------------------
	// Program counter
	// --------------------
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= reset_vector;
		end else if (branch_taken) begin
			// Redirect wins over a load-use hold
			pc <= branch_target;
		end else if (!stall) begin
			pc <= next_sequential;
		end
	end

	// --------------------
	// IF/ID register
	// --------------------
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			instruction <= nop;
		end else if (!stall) begin
			instruction <= instruction_in;
		end
	end

	// Return address payload, meaningless under a nop
	always_ff @(posedge clock) begin
		if (!stall) begin
			pc_plus4 <= next_sequential;
		end
	end

	// Branch targets come from execute, fetch must stay on word boundaries
	a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		pc[1:0] == 2'b00);

endmodule

//--- hw/mips_pkg.sv
/*
 * Shared widths, encodings and ALU select codes for the pipelined MIPS core.
 * Every stage module imports this package in its header.
 */
package mips_pkg;

	// --------------------
	// Widths and types
	// --------------------
	localparam int word_width = 32;
	localparam int reg_addr_width = 5;

	// Data or address word
	typedef logic [word_width-1:0] word_t;
	// Register number
	typedef logic [reg_addr_width-1:0] reg_addr_t;
	typedef logic [4:0] shamt_t;
	typedef logic [3:0] alu_op_t;
	typedef logic [5:0] opcode_t;

	// All-zero word, sll $0,$0,0
	localparam word_t nop = '0;

	// --------------------
	// Primary opcodes
	// --------------------
	localparam opcode_t op_special = 6'h00;
	localparam opcode_t op_beq = 6'h04;
	localparam opcode_t op_addiu = 6'h09;
	localparam opcode_t op_andi = 6'h0c;
	localparam opcode_t op_ori = 6'h0d;
	localparam opcode_t op_lui = 6'h0f;
	localparam opcode_t op_lw = 6'h23;
	localparam opcode_t op_sw = 6'h2b;

	// --------------------
	// Funct field, special only
	// --------------------
	localparam opcode_t fn_sll = 6'h00;
	localparam opcode_t fn_syscall = 6'h0c;
	localparam opcode_t fn_addu = 6'h21;
	localparam opcode_t fn_subu = 6'h23;
	localparam opcode_t fn_and = 6'h24;
	localparam opcode_t fn_or = 6'h25;
	localparam opcode_t fn_slt = 6'h2a;

	// ALU select codes
	localparam alu_op_t alu_add = 4'd0;
	localparam alu_op_t alu_sub = 4'd1;
	localparam alu_op_t alu_and = 4'd2;
	localparam alu_op_t alu_or = 4'd3;
	localparam alu_op_t alu_slt = 4'd4;
	localparam alu_op_t alu_sll = 4'd5;
	// Immediate into upper half
	localparam alu_op_t alu_lui = 4'd6;

endpackage
